// ==== hdl/nlc_cfg.svh ====
`ifndef NLC_CFG_SVH
`define NLC_CFG_SVH

// sensor channels handled per batch
`define NLC_CHANNELS 16

// raw adc sample and corrected sample width
`define NLC_SAMPLE_W 21

// word width of the external arithmetic units
`define NLC_WORD_W 32

// fifth-order correction polynomial, six coefficients
`define NLC_ORDER 5

`endif

// ==== hdl/nlc_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_datapath import nlc_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  phase_t      phase,
  input  order_t      coeff_sel,
  input  ch_idx_t     mul_ch,
  input  ch_idx_t     out_ch,
  input  ch_idx_t     wr_ch,
  input  wire         norm_we,
  input  wire         acc_we,
  input  wire         xlin_we,
  input  word_t       conv_in_result,
  input  word_t       add_sum,
  input  word_t       mul_product,
  input  word_t       neg_mean,
  input  word_t       recip_stdev,
  input  word_t       add_coeff,
  input  word_t       lead_coeff,
  input  sample_t     conv_out_result,
  output word_t       add_a,
  output word_t       add_b,
  output word_t       mul_a,
  output word_t       mul_b,
  output word_t       conv_out_data,
  output sample_arr_t x_lin
);

  word_arr_t norm_q;
  word_arr_t acc_q;
  logic      first_round;

  // accumulator still empty, start from the leading coefficient
  assign first_round = (coeff_sel == order_t'(`NLC_ORDER - 1));

  always_comb begin
    if (phase == ph_normalize) begin
      // (x + neg_mean) * recip_stdev
      add_a = conv_in_result;
      add_b = neg_mean;
      mul_a = add_sum;
      mul_b = recip_stdev;
    end else begin
      // acc * n + coeff_k
      add_a = mul_product;
      add_b = add_coeff;
      mul_a = first_round ? lead_coeff : acc_q[mul_ch];
      mul_b = norm_q[mul_ch];
    end
  end

  assign conv_out_data = acc_q[out_ch];

  always_ff @(posedge clk) begin
    if (norm_we) begin
      norm_q[wr_ch] <= mul_product;
    end
    if (acc_we) begin
      acc_q[wr_ch] <= add_sum;
    end
    if (xlin_we) begin
      x_lin[wr_ch] <= conv_out_result;
    end
  end

  // each phase writes back through a single unit
  a_one_write: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({norm_we, acc_we, xlin_we})
  ) else $error("more than one write enable active");

endmodule

`default_nettype wire

// ==== hdl/nlc_param_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_param_bank import nlc_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         srdyi,
  input  wire         accept,
  input  sample_arr_t x_adc_in,
  input  word_arr_t   neg_mean_in,
  input  word_arr_t   recip_stdev_in,
  input  coeff_arr_t  coeff_in,
  input  ch_idx_t     conv_ch,
  input  ch_idx_t     add_ch,
  input  ch_idx_t     mul_ch,
  input  order_t      coeff_sel,
  output word_t       adc_word,
  output word_t       neg_mean,
  output word_t       recip_stdev,
  output word_t       add_coeff,
  output word_t       lead_coeff
);

  localparam int EXT_W = `NLC_WORD_W - `NLC_SAMPLE_W;

  sample_arr_t adc_q;
  word_arr_t   neg_mean_q;
  word_arr_t   recip_stdev_q;
  coeff_arr_t  coeff_q;
  sample_t     adc_sel;

  // whole batch captured at once, busy strobes ignored
  always_ff @(posedge clk) begin
    if (srdyi && accept) begin
      adc_q         <= x_adc_in;
      neg_mean_q    <= neg_mean_in;
      recip_stdev_q <= recip_stdev_in;
      coeff_q       <= coeff_in;
    end
  end

  // input converter takes the sample as a signed word
  assign adc_sel  = adc_q[conv_ch];
  assign adc_word = {{EXT_W{adc_sel[`NLC_SAMPLE_W-1]}}, adc_sel};

  // normalize adds follow the adder issue order
  assign neg_mean = neg_mean_q[add_ch];

  assign recip_stdev = recip_stdev_q[mul_ch];

  // horner adds pick coefficient k of the current round
  assign add_coeff = coeff_q[add_ch][coeff_sel];

  // seeds the first horner multiply
  assign lead_coeff = coeff_q[mul_ch][`NLC_ORDER];

  a_index_range: assert property (
    @(posedge clk) disable iff (rst)
    (32'(conv_ch) < `NLC_CHANNELS) && (32'(add_ch) < `NLC_CHANNELS) &&
    (32'(mul_ch) < `NLC_CHANNELS) && (32'(coeff_sel) <= `NLC_ORDER)
  ) else $error("bank read index out of range");

endmodule

`default_nettype wire

// ==== hdl/nlc_pkg.sv ====
`default_nettype none

`include "nlc_cfg.svh"

package nlc_pkg;

  typedef logic [`NLC_SAMPLE_W-1:0] sample_t;
  typedef logic [`NLC_WORD_W-1:0] word_t;

  // wide enough for NLC_CHANNELS
  typedef logic [3:0] ch_idx_t;

  // coefficient index 0 to NLC_ORDER
  typedef logic [2:0] order_t;

  typedef enum logic [1:0] {
    ph_idle,
    ph_normalize,
    ph_horner,
    ph_convert_out
  } phase_t;

  typedef logic [`NLC_CHANNELS-1:0][`NLC_SAMPLE_W-1:0] sample_arr_t;
  typedef logic [`NLC_CHANNELS-1:0][`NLC_WORD_W-1:0] word_arr_t;
  typedef logic [`NLC_CHANNELS-1:0][`NLC_ORDER:0][`NLC_WORD_W-1:0] coeff_arr_t;

endpackage

`default_nettype wire

// ==== hdl/nlc_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_scheduler import nlc_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  wire     srdyi,
  input  wire     conv_in_done,
  input  wire     add_done,
  input  wire     mul_done,
  input  wire     conv_out_done,
  output logic    accept,
  output logic    srdyo,
  output logic    conv_in_start,
  output logic    add_start,
  output logic    mul_start,
  output logic    conv_out_start,
  output logic    norm_we,
  output logic    acc_we,
  output logic    xlin_we,
  output phase_t  phase,
  output order_t  coeff_sel,
  output ch_idx_t conv_ch,
  output ch_idx_t add_ch,
  output ch_idx_t mul_ch,
  output ch_idx_t out_ch,
  output ch_idx_t wr_ch
);

  localparam int CNT_W = $clog2(`NLC_CHANNELS) + 1;
  localparam logic [CNT_W-1:0] CH_CNT = CNT_W'(`NLC_CHANNELS);
  localparam logic [CNT_W-1:0] CH_LAST = CNT_W'(`NLC_CHANNELS - 1);
  localparam order_t FIRST_ROUND = order_t'(`NLC_ORDER - 1);

  // issue counters, one per unit
  logic [CNT_W-1:0] conv_cnt;
  logic [CNT_W-1:0] add_cnt;
  logic [CNT_W-1:0] mul_cnt;
  logic [CNT_W-1:0] out_cnt;
  // results written back in the current phase or round
  logic [CNT_W-1:0] wr_cnt;

  order_t round;
  logic   start_batch;
  logic   wr_fire;
  logic   last_wr;
  logic   clr_cnt;

  assign accept      = (phase == ph_idle);
  assign start_batch = accept && srdyi;

  assign wr_fire = norm_we || acc_we || xlin_we;
  assign last_wr = wr_fire && (wr_cnt == CH_LAST);
  assign clr_cnt = start_batch || last_wr;

  assign coeff_sel = round;
  assign conv_ch   = ch_idx_t'(conv_cnt);
  assign add_ch    = ch_idx_t'(add_cnt);
  assign mul_ch    = ch_idx_t'(mul_cnt);
  assign out_ch    = ch_idx_t'(out_cnt);
  assign wr_ch     = ch_idx_t'(wr_cnt);

  // results return in order, so a done launches the next step at once
  always_comb begin
    conv_in_start  = 1'b0;
    add_start      = 1'b0;
    mul_start      = 1'b0;
    conv_out_start = 1'b0;
    norm_we        = 1'b0;
    acc_we         = 1'b0;
    xlin_we        = 1'b0;
    case (phase)
      ph_normalize: begin
        conv_in_start = (conv_cnt < CH_CNT);
        add_start     = conv_in_done;
        mul_start     = add_done;
        norm_we       = mul_done;
      end
      ph_horner: begin
        mul_start = (mul_cnt < CH_CNT);
        add_start = mul_done;
        acc_we    = add_done;
      end
      ph_convert_out: begin
        conv_out_start = (out_cnt < CH_CNT);
        xlin_we        = conv_out_done;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || clr_cnt) begin
      conv_cnt <= '0;
      add_cnt  <= '0;
      mul_cnt  <= '0;
      out_cnt  <= '0;
      wr_cnt   <= '0;
    end else begin
      if (conv_in_start) begin
        conv_cnt <= conv_cnt + 1'b1;
      end
      if (add_start) begin
        add_cnt <= add_cnt + 1'b1;
      end
      if (mul_start) begin
        mul_cnt <= mul_cnt + 1'b1;
      end
      if (conv_out_start) begin
        out_cnt <= out_cnt + 1'b1;
      end
      if (wr_fire) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= ph_idle;
      round <= FIRST_ROUND;
      srdyo <= 1'b0;
    end else begin
      case (phase)
        ph_idle: begin
          if (srdyi) begin
            phase <= ph_normalize;
            round <= FIRST_ROUND;
            srdyo <= 1'b0;
          end
        end
        ph_normalize: begin
          if (last_wr) begin
            phase <= ph_horner;
          end
        end
        ph_horner: begin
          // round ends once every accumulator is back
          if (last_wr) begin
            if (round == '0) begin
              phase <= ph_convert_out;
            end else begin
              round <= round - 1'b1;
            end
          end
        end
        default: begin
          if (last_wr) begin
            phase <= ph_idle;
            srdyo <= 1'b1;
          end
        end
      endcase
    end
  end

  a_conv_in_pending: assert property (
    @(posedge clk) disable iff (rst)
    conv_in_done |-> (phase == ph_normalize) && (add_cnt < conv_cnt)
  ) else $error("conv_in_done without pending conversion");

  a_add_pending: assert property (
    @(posedge clk) disable iff (rst)
    add_done |-> ((phase == ph_normalize) && (mul_cnt < add_cnt)) ||
                 ((phase == ph_horner) && (wr_cnt < add_cnt))
  ) else $error("add_done without pending add");

  a_mul_pending: assert property (
    @(posedge clk) disable iff (rst)
    mul_done |-> ((phase == ph_normalize) && (wr_cnt < mul_cnt)) ||
                 ((phase == ph_horner) && (add_cnt < mul_cnt))
  ) else $error("mul_done without pending multiply");

  a_conv_out_pending: assert property (
    @(posedge clk) disable iff (rst)
    conv_out_done |-> (phase == ph_convert_out) && (wr_cnt < out_cnt)
  ) else $error("conv_out_done without pending conversion");

  a_srdyo_idle: assert property (
    @(posedge clk) disable iff (rst)
    srdyo |-> (phase == ph_idle)
  ) else $error("srdyo high while busy");

endmodule

`default_nettype wire

// ==== hdl/nlc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module nlc_top import nlc_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         srdyi,
  output logic        srdyo,
  input  sample_arr_t x_adc_in,
  input  word_arr_t   neg_mean_in,
  input  word_arr_t   recip_stdev_in,
  input  coeff_arr_t  coeff_in,
  output sample_arr_t x_lin,
  output logic        conv_in_start,
  output word_t       conv_in_data,
  input  wire         conv_in_done,
  input  word_t       conv_in_result,
  output logic        add_start,
  output word_t       add_a,
  output word_t       add_b,
  input  wire         add_done,
  input  word_t       add_sum,
  output logic        mul_start,
  output word_t       mul_a,
  output word_t       mul_b,
  input  wire         mul_done,
  input  word_t       mul_product,
  output logic        conv_out_start,
  output word_t       conv_out_data,
  input  wire         conv_out_done,
  input  sample_t     conv_out_result
);

  logic    accept;
  phase_t  phase;
  order_t  coeff_sel;
  ch_idx_t conv_ch;
  ch_idx_t add_ch;
  ch_idx_t mul_ch;
  ch_idx_t out_ch;
  ch_idx_t wr_ch;
  logic    norm_we;
  logic    acc_we;
  logic    xlin_we;
  word_t   neg_mean;
  word_t   recip_stdev;
  word_t   add_coeff;
  word_t   lead_coeff;

  nlc_param_bank bank_inst (
    .clk            (clk),
    .rst            (rst),
    .srdyi          (srdyi),
    .accept         (accept),
    .x_adc_in       (x_adc_in),
    .neg_mean_in    (neg_mean_in),
    .recip_stdev_in (recip_stdev_in),
    .coeff_in       (coeff_in),
    .conv_ch        (conv_ch),
    .add_ch         (add_ch),
    .mul_ch         (mul_ch),
    .coeff_sel      (coeff_sel),
    .adc_word       (conv_in_data),
    .neg_mean       (neg_mean),
    .recip_stdev    (recip_stdev),
    .add_coeff      (add_coeff),
    .lead_coeff     (lead_coeff)
  );

  nlc_scheduler sched_inst (
    .clk            (clk),
    .rst            (rst),
    .srdyi          (srdyi),
    .conv_in_done   (conv_in_done),
    .add_done       (add_done),
    .mul_done       (mul_done),
    .conv_out_done  (conv_out_done),
    .accept         (accept),
    .srdyo          (srdyo),
    .conv_in_start  (conv_in_start),
    .add_start      (add_start),
    .mul_start      (mul_start),
    .conv_out_start (conv_out_start),
    .norm_we        (norm_we),
    .acc_we         (acc_we),
    .xlin_we        (xlin_we),
    .phase          (phase),
    .coeff_sel      (coeff_sel),
    .conv_ch        (conv_ch),
    .add_ch         (add_ch),
    .mul_ch         (mul_ch),
    .out_ch         (out_ch),
    .wr_ch          (wr_ch)
  );

  nlc_datapath dp_inst (
    .clk             (clk),
    .rst             (rst),
    .phase           (phase),
    .coeff_sel       (coeff_sel),
    .mul_ch          (mul_ch),
    .out_ch          (out_ch),
    .wr_ch           (wr_ch),
    .norm_we         (norm_we),
    .acc_we          (acc_we),
    .xlin_we         (xlin_we),
    .conv_in_result  (conv_in_result),
    .add_sum         (add_sum),
    .mul_product     (mul_product),
    .neg_mean        (neg_mean),
    .recip_stdev     (recip_stdev),
    .add_coeff       (add_coeff),
    .lead_coeff      (lead_coeff),
    .conv_out_result (conv_out_result),
    .add_a           (add_a),
    .add_b           (add_b),
    .mul_a           (mul_a),
    .mul_b           (mul_b),
    .conv_out_data   (conv_out_data),
    .x_lin           (x_lin)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module nlc_tb -f vlog.f -o nlc_sim
./obj_dir/nlc_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"

// ==== sim/nlc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_tb import nlc_pkg::*; ();

  localparam int CLK_PERIOD    = 10;
  localparam int BATCH_CYCLES  = 2000;
  localparam int WATCH_BATCHES = 20;
  localparam int CH            = `NLC_CHANNELS;
  localparam int EXT_W         = `NLC_WORD_W - `NLC_SAMPLE_W;

  logic        clk = 1'b0;
  logic        rst;
  logic        srdyi;
  logic        srdyo;
  sample_arr_t x_adc_in;
  word_arr_t   neg_mean_in;
  word_arr_t   recip_stdev_in;
  coeff_arr_t  coeff_in;
  sample_arr_t x_lin;
  logic        conv_in_start;
  logic        conv_in_done;
  logic        add_start;
  logic        add_done;
  logic        mul_start;
  logic        mul_done;
  logic        conv_out_start;
  logic        conv_out_done;
  word_t       conv_in_data;
  word_t       conv_in_result;
  word_t       add_a;
  word_t       add_b;
  word_t       add_sum;
  word_t       mul_a;
  word_t       mul_b;
  word_t       mul_product;
  word_t       conv_out_data;
  sample_t     conv_out_result;

  // copy of the batch that the DUT accepted
  sample_arr_t ref_adc;
  word_arr_t   ref_nm;
  word_arr_t   ref_rs;
  coeff_arr_t  ref_coeff;

  integer seed = 17;
  string  cur_test;
  int     test_errors;
  int     total_errors = 0;
  int     total_checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     n_cin = 0;
  int     n_add = 0;
  int     n_mul = 0;
  int     n_cout = 0;
  int     s_cin;
  int     s_add;
  int     s_mul;
  int     s_cout;

  nlc_top nlc_top_inst (.*);

  nlc_units_model units_inst (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // free-running start counters differenced per batch
  always @(posedge clk) begin
    n_cin  <= n_cin + int'(conv_in_start);
    n_add  <= n_add + int'(add_start);
    n_mul  <= n_mul + int'(mul_start);
    n_cout <= n_cout + int'(conv_out_start);
  end

  // conversion operands leave in channel order as sign-extended samples
  always @(negedge clk) begin
    int idx;
    idx = n_cin - s_cin;
    if (conv_in_start && idx >= 0 && idx < CH) begin
      check_value($sformatf("conv_in_data[%0d]", idx),
                  {{EXT_W{ref_adc[idx][`NLC_SAMPLE_W-1]}}, ref_adc[idx]}, conv_in_data);
    end
  end

  initial begin
    #(WATCH_BATCHES * BATCH_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the simulation did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    total_checks++;
    assert (exp == act) else begin
      $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic begin_test(string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "failed",
             test_errors);
  endtask

  task automatic randomize_inputs();
    for (int c = 0; c < CH; c++) begin
      x_adc_in[c]       = sample_t'($random(seed));
      neg_mean_in[c]    = word_t'($random(seed));
      recip_stdev_in[c] = word_t'($random(seed));
      for (int k = 0; k <= `NLC_ORDER; k++) begin
        coeff_in[c][k] = word_t'($random(seed));
      end
    end
  endtask

  // normalize and run horner from coeff5 down to coeff0
  function automatic sample_t expected_sample(int c);
    word_t n;
    word_t acc;
    n   = ({{EXT_W{ref_adc[c][`NLC_SAMPLE_W-1]}}, ref_adc[c]} + ref_nm[c]) * ref_rs[c];
    acc = ref_coeff[c][`NLC_ORDER];
    for (int k = `NLC_ORDER - 1; k >= 0; k--) begin
      acc = acc * n + ref_coeff[c][k];
    end
    return acc[`NLC_SAMPLE_W-1:0];
  endfunction

  task automatic launch();
    ref_adc   = x_adc_in;
    ref_nm    = neg_mean_in;
    ref_rs    = recip_stdev_in;
    ref_coeff = coeff_in;
    s_cin     = n_cin;
    s_add     = n_add;
    s_mul     = n_mul;
    s_cout    = n_cout;
    srdyi     = 1'b1;
    tick();
    srdyi = 1'b0;
    check_value("srdyo after srdyi", 32'd0, 32'(srdyo));
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!srdyo && cycles < BATCH_CYCLES) begin
      tick();
      cycles++;
    end
    total_checks++;
    assert (srdyo) else begin
      $display("%s: srdyo never rose within %0d cycles", cur_test, BATCH_CYCLES);
      test_errors++;
    end
  endtask

  task automatic check_results();
    for (int c = 0; c < CH; c++) begin
      check_value($sformatf("x_lin[%0d]", c), 32'(expected_sample(c)), 32'(x_lin[c]));
    end
  endtask

  task automatic check_counts();
    check_value("conv_in starts", 32'(CH), 32'(n_cin - s_cin));
    check_value("add starts", 32'(CH * (`NLC_ORDER + 1)), 32'(n_add - s_add));
    check_value("mul starts", 32'(CH * (`NLC_ORDER + 1)), 32'(n_mul - s_mul));
    check_value("conv_out starts", 32'(CH), 32'(n_cout - s_cout));
  endtask

  task automatic run_batch();
    randomize_inputs();
    launch();
    wait_done();
    check_results();
  endtask

  initial begin
    rst            = 1'b1;
    srdyi          = 1'b0;
    x_adc_in       = '0;
    neg_mean_in    = '0;
    recip_stdev_in = '0;
    coeff_in       = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("idle_after_reset");
    repeat (20) begin
      tick();
      check_value("srdyo", 32'd0, 32'(srdyo));
      check_value("starts", 32'd0,
                  32'({conv_in_start, add_start, mul_start, conv_out_start}));
    end
    end_test();

    begin_test("single_batch");
    run_batch();
    end_test();

    begin_test("back_to_back");
    repeat (10) begin
      run_batch();
    end
    end_test();

    begin_test("busy_srdyi_ignored");
    randomize_inputs();
    launch();
    repeat (5) tick();
    randomize_inputs();
    srdyi = 1'b1;
    tick();
    srdyi = 1'b0;
    wait_done();
    check_results();
    end_test();

    begin_test("coeff0_only");
    randomize_inputs();
    for (int c = 0; c < CH; c++) begin
      for (int k = 1; k <= `NLC_ORDER; k++) begin
        coeff_in[c][k] = '0;
      end
    end
    launch();
    wait_done();
    for (int c = 0; c < CH; c++) begin
      check_value($sformatf("x_lin[%0d]", c), 32'(coeff_in[c][0][`NLC_SAMPLE_W-1:0]),
                  32'(x_lin[c]));
    end
    end_test();

    begin_test("adc_extremes");
    randomize_inputs();
    for (int c = 0; c < CH; c++) begin
      // most negative on even channels and most positive on odd ones
      x_adc_in[c] = {1'b1, {(`NLC_SAMPLE_W - 1){1'b0}}};
      if (c % 2 == 1) begin
        x_adc_in[c] = ~x_adc_in[c];
      end
    end
    launch();
    wait_done();
    check_results();
    end_test();

    begin_test("start_counts");
    run_batch();
    check_counts();
    end_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/nlc_units_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_units_model import nlc_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  wire     conv_in_start,
  input  word_t   conv_in_data,
  output logic    conv_in_done,
  output word_t   conv_in_result,
  input  wire     add_start,
  input  word_t   add_a,
  input  word_t   add_b,
  output logic    add_done,
  output word_t   add_sum,
  input  wire     mul_start,
  input  word_t   mul_a,
  input  word_t   mul_b,
  output logic    mul_done,
  output word_t   mul_product,
  input  wire     conv_out_start,
  input  word_t   conv_out_data,
  output logic    conv_out_done,
  output sample_t conv_out_result
);

  localparam int CONV_LAT = 2;
  localparam int ADD_LAT  = 7;
  localparam int MUL_LAT  = 6;
  localparam int EXT_W    = `NLC_WORD_W - `NLC_SAMPLE_W;

  logic [CONV_LAT-1:0] cin_v;
  logic [ADD_LAT-1:0]  add_v;
  logic [MUL_LAT-1:0]  mul_v;
  logic [CONV_LAT-1:0] cout_v;
  word_t   cin_d  [CONV_LAT];
  word_t   add_d  [ADD_LAT];
  word_t   mul_d  [MUL_LAT];
  sample_t cout_d [CONV_LAT];

  always_ff @(posedge clk) begin
    if (rst) begin
      cin_v  <= '0;
      add_v  <= '0;
      mul_v  <= '0;
      cout_v <= '0;
    end else begin
      cin_v  <= {cin_v[CONV_LAT-2:0], conv_in_start};
      add_v  <= {add_v[ADD_LAT-2:0], add_start};
      mul_v  <= {mul_v[MUL_LAT-2:0], mul_start};
      cout_v <= {cout_v[CONV_LAT-2:0], conv_out_start};
    end
  end

  // fully pipelined, results leave in issue order
  always_ff @(posedge clk) begin
    cin_d[0]  <= {{EXT_W{conv_in_data[`NLC_SAMPLE_W-1]}}, conv_in_data[`NLC_SAMPLE_W-1:0]};
    add_d[0]  <= add_a + add_b;
    mul_d[0]  <= mul_a * mul_b;
    cout_d[0] <= conv_out_data[`NLC_SAMPLE_W-1:0];
    for (int i = 1; i < CONV_LAT; i++) begin
      cin_d[i]  <= cin_d[i-1];
      cout_d[i] <= cout_d[i-1];
    end
    for (int i = 1; i < ADD_LAT; i++) begin
      add_d[i] <= add_d[i-1];
    end
    for (int i = 1; i < MUL_LAT; i++) begin
      mul_d[i] <= mul_d[i-1];
    end
  end

  assign conv_in_done    = cin_v[CONV_LAT-1];
  assign conv_in_result  = cin_d[CONV_LAT-1];
  assign add_done        = add_v[ADD_LAT-1];
  assign add_sum         = add_d[ADD_LAT-1];
  assign mul_done        = mul_v[MUL_LAT-1];
  assign mul_product     = mul_d[MUL_LAT-1];
  assign conv_out_done   = cout_v[CONV_LAT-1];
  assign conv_out_result = cout_d[CONV_LAT-1];

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/nlc_pkg.sv
hdl/nlc_param_bank.sv
hdl/nlc_scheduler.sv
hdl/nlc_datapath.sv
hdl/nlc_top.sv
sim/nlc_units_model.sv
sim/nlc_tb.sv
